/* Makefile */
# Verilator build and run for the player input subsystem

VERILATOR ?= verilator
TOP       ?= tb_invaders_input
FLIST     ?= invaders_input.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/invaders_checker.sv */
`timescale 1ns/1ps

`include "invaders_macros.svh"

module invaders_checker #(
	parameter int EXP_PULSES = 2
) (
	input  logic              clk_mist,
	input  logic              arst_n,
	input  logic              ctrl_req,
	input  logic              ctrl_ack,
	input  logic [`CTRL_W-1:0] ctrl_data,
	input  logic              check_en,
	input  logic [`CTRL_W-1:0] expected,
	input  logic              final_en,
	output int                data_errors,
	output int                proto_errors
);

	logic                           prev_req;
	logic                           prev_ack;
	logic                           prev_rst_n;
	logic [`CTRL_W-1:0]             prev_data;
	int                             coin_len;
	int                             pulse_count;
	invaders_input_pkg::ctrl_word_t delivered;
	invaders_input_pkg::hs_state_t  phase;

	assign delivered = ctrl_data;

	initial begin
		data_errors  = 0;
		proto_errors = 0;
		coin_len     = 0;
		pulse_count  = 0;
		prev_req     = 1'b0;
		prev_ack     = 1'b0;
		prev_rst_n   = 1'b0;
		prev_data    = '0;
	end

	always @(posedge clk_mist) begin
		if (!arst_n) begin
			prev_rst_n = 1'b0;
		end else begin
			// link phase as seen from the ports
			if (prev_req)
				phase = invaders_input_pkg::req_high;
			else if (prev_ack)
				phase = invaders_input_pkg::wait_release;
			else
				phase = invaders_input_pkg::idle;
			if (!prev_rst_n && (ctrl_req || ctrl_data != '0)) begin
				$display("ctrl_req or ctrl_data not zero after reset");
				proto_errors++;
			end
			if (prev_rst_n && prev_req && !ctrl_req && !prev_ack) begin
				$display("ctrl_req dropped in %s before ctrl_ack came", phase.name());
				proto_errors++;
			end
			if (prev_rst_n && prev_req && ctrl_req && ctrl_data != prev_data) begin
				$display("ctrl_data changed in %s while ctrl_req was high", phase.name());
				proto_errors++;
			end
			if (prev_rst_n && !prev_req && ctrl_req && prev_ack) begin
				$display("ctrl_req rose in %s while ctrl_ack was still high", phase.name());
				proto_errors++;
			end
			// coin length in the delivered stream
			if (delivered.coin) begin
				coin_len++;
			end else if (coin_len != 0) begin
				pulse_count++;
				if (coin_len != `COIN_PULSE_CYCLES) begin
					$display("CHECK FAILED coin pulse length: got %h expected %h",
						coin_len, `COIN_PULSE_CYCLES);
					data_errors++;
				end
				coin_len = 0;
			end
			if (check_en && ctrl_data != expected) begin
				$display("CHECK FAILED ctrl_data: got %h expected %h", ctrl_data, expected);
				data_errors++;
			end
			if (final_en && pulse_count != EXP_PULSES) begin
				$display("CHECK FAILED coin pulse count: got %h expected %h",
					pulse_count, EXP_PULSES);
				data_errors++;
			end
			prev_rst_n = 1'b1;
		end
		prev_req  = ctrl_req;
		prev_ack  = ctrl_ack;
		prev_data = ctrl_data;
	end

endmodule

/* bench/tb_invaders_input.sv */
`timescale 1ns/1ps

`include "invaders_macros.svh"

module tb_invaders_input;

	typedef struct packed {
		logic              strobe;
		logic              pressed;
		logic [7:0]        code;
		logic [`JOY_W-1:0] joy0;
		logic [`JOY_W-1:0] joy1;
		logic              rot;
		logic              slow;
		logic              check;
		logic [7:0]        hold;
		logic [`CTRL_W-1:0] exp_word;
	} row_t;

	localparam int NUM_ROWS = 39;

	// strobe pressed code joy0 joy1 rotate slow_ack check hold expected
	localparam row_t ROWS [NUM_ROWS] = '{
		'{1'b1, 1'b1, 8'h75, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h008},
		'{1'b1, 1'b0, 8'h75, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h000},
		'{1'b1, 1'b1, 8'h74, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h002},
		'{1'b1, 1'b0, 8'h74, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h000},
		'{1'b1, 1'b1, 8'h6B, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h001},
		'{1'b1, 1'b0, 8'h6B, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h000},
		'{1'b1, 1'b1, 8'h72, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h004},
		'{1'b1, 1'b0, 8'h72, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h000},
		'{1'b1, 1'b1, 8'h05, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h080},
		'{1'b1, 1'b0, 8'h05, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h000},
		'{1'b1, 1'b1, 8'h06, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h040},
		'{1'b1, 1'b0, 8'h06, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h000},
		'{1'b1, 1'b1, 8'h29, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h020},
		'{1'b1, 1'b0, 8'h29, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h000},
		'{1'b1, 1'b1, 8'h11, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h010},
		'{1'b1, 1'b0, 8'h11, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h000},
		'{1'b1, 1'b1, 8'h14, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h000},
		'{1'b1, 1'b0, 8'h14, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h000},
		'{1'b1, 1'b1, 8'h1C, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h000},
		'{1'b0, 1'b0, 8'h00, 8'h01, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h002},
		'{1'b0, 1'b0, 8'h00, 8'h00, 8'h02, 1'b0, 1'b1, 1'b1, 8'd30, 9'h001},
		'{1'b0, 1'b0, 8'h00, 8'h04, 8'h00, 1'b1, 1'b1, 1'b1, 8'd30, 9'h001},
		'{1'b0, 1'b0, 8'h00, 8'h00, 8'h08, 1'b1, 1'b1, 1'b1, 8'd30, 9'h002},
		'{1'b0, 1'b0, 8'h00, 8'h00, 8'h01, 1'b1, 1'b1, 1'b1, 8'd30, 9'h004},
		'{1'b0, 1'b0, 8'h00, 8'h02, 8'h00, 1'b1, 1'b1, 1'b1, 8'd30, 9'h008},
		'{1'b0, 1'b0, 8'h00, 8'h30, 8'h00, 1'b1, 1'b1, 1'b1, 8'd30, 9'h030},
		'{1'b1, 1'b1, 8'h75, 8'h00, 8'h08, 1'b1, 1'b1, 1'b1, 8'd30, 9'h002},
		'{1'b1, 1'b0, 8'h75, 8'h00, 8'h00, 1'b1, 1'b1, 1'b1, 8'd30, 9'h000},
		// coin presses with prompt acks
		'{1'b1, 1'b1, 8'h76, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 8'd40, 9'h000},
		'{1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 8'd20, 9'h000},
		'{1'b1, 1'b0, 8'h76, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 8'd20, 9'h000},
		'{1'b1, 1'b1, 8'h76, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 8'd40, 9'h000},
		'{1'b1, 1'b0, 8'h76, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 8'd20, 9'h000},
		// rapid changes against slow acks
		'{1'b1, 1'b1, 8'h75, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0, 8'd2,  9'h008},
		'{1'b0, 1'b0, 8'h00, 8'h01, 8'h00, 1'b0, 1'b1, 1'b0, 8'd2,  9'h00A},
		'{1'b1, 1'b1, 8'h29, 8'h01, 8'h00, 1'b0, 1'b1, 1'b0, 8'd3,  9'h02A},
		'{1'b0, 1'b0, 8'h00, 8'h00, 8'h20, 1'b0, 1'b1, 1'b0, 8'd2,  9'h038},
		'{1'b1, 1'b0, 8'h75, 8'h00, 8'h20, 1'b0, 1'b1, 1'b1, 8'd30, 9'h030},
		'{1'b1, 1'b0, 8'h29, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'd30, 9'h000}
	};

	logic               clk_mist = 1'b0;
	logic               arst_n;
	logic               key_strobe;
	logic               key_pressed;
	logic [7:0]         key_code;
	logic [`JOY_W-1:0]  joystick_0;
	logic [`JOY_W-1:0]  joystick_1;
	logic               rotate;
	logic               ctrl_ack = 1'b0;
	logic               ctrl_req;
	logic [`CTRL_W-1:0] ctrl_data;
	logic               slow_ack;
	logic               check_en;
	logic [`CTRL_W-1:0] expected;
	logic               final_en;
	logic [2:0]         ack_wait = 3'd0;
	logic [31:0]        rng = 32'd94;
	int                 data_errors;
	int                 proto_errors;
	int                 cycles = 0;
	int                 limit = 0;

	always #10 clk_mist = ~clk_mist;

	invaders_input_top dut0 (
		.clk_mist    (clk_mist),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.rotate      (rotate),
		.ctrl_ack    (ctrl_ack),
		.ctrl_req    (ctrl_req),
		.ctrl_data   (ctrl_data)
	);

	invaders_checker checker0 (
		.clk_mist     (clk_mist),
		.arst_n       (arst_n),
		.ctrl_req     (ctrl_req),
		.ctrl_ack     (ctrl_ack),
		.ctrl_data    (ctrl_data),
		.check_en     (check_en),
		.expected     (expected),
		.final_en     (final_en),
		.data_errors  (data_errors),
		.proto_errors (proto_errors)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// core side of the link with a random delay per phase
	always @(posedge clk_mist or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_ack <= 1'b0;
			ack_wait <= 3'd0;
			rng      <= 32'd94;
		end else if (ctrl_req == ctrl_ack) begin
			ack_wait <= slow_ack ? rng[2:0] : 3'd0;
			rng      <= xorshift(rng);
		end else if (ack_wait == 3'd0) begin
			ctrl_ack <= ctrl_req; // follow req after the delay
		end else begin
			ack_wait <= ack_wait - 3'd1;
		end
	end

	always @(posedge clk_mist) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles > limit) begin
			$display("timeout after %0d cycles, the link never settled", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic apply_row(input int idx);
		row_t r;
		int   quiet;
		r = ROWS[idx];
		key_strobe  <= r.strobe;
		key_pressed <= r.pressed;
		key_code    <= r.code;
		joystick_0  <= r.joy0;
		joystick_1  <= r.joy1;
		rotate      <= r.rot;
		slow_ack    <= r.slow;
		@(posedge clk_mist);
		key_strobe <= 1'b0;
		repeat (int'(r.hold) - 1) @(posedge clk_mist);
		if (r.check) begin
			quiet = 0;
			while (quiet < 3) begin
				quiet = (!ctrl_req && !ctrl_ack) ? quiet + 1 : 0; // no transfer open
				@(posedge clk_mist);
			end
			check_en <= 1'b1;
			expected <= r.exp_word;
			@(posedge clk_mist);
			check_en <= 1'b0;
		end
	endtask

	initial begin
		int total;
		arst_n      = 1'b0;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = 8'h00;
		joystick_0  = '0;
		joystick_1  = '0;
		rotate      = 1'b0;
		slow_ack    = 1'b1;
		check_en    = 1'b0;
		expected    = '0;
		final_en    = 1'b0;
		total = 20;
		for (int i = 0; i < NUM_ROWS; i++) begin
			total += int'(ROWS[i].hold) + 40;
		end
		limit = total;
		repeat (5) @(posedge clk_mist);
		arst_n <= 1'b1;
		@(posedge clk_mist);
		for (int i = 0; i < NUM_ROWS; i++) begin
			apply_row(i);
		end
		final_en <= 1'b1;
		@(posedge clk_mist);
		final_en <= 1'b0;
		@(posedge clk_mist);
		@(posedge clk_mist);
		$display("errors: %0d data, %0d protocol", data_errors, proto_errors);
		if (data_errors == 0 && proto_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* design/coin_pulse_timer.sv */
`timescale 1ns/1ps

`include "invaders_macros.svh"

module coin_pulse_timer (
	input  logic clk_mist,
	input  logic arst_n,
	input  logic coin_key,
	output logic coin_pulse
);

	localparam int CNT_W = $clog2(`COIN_PULSE_CYCLES + 1);

	logic [CNT_W-1:0] count;
	logic             armed;

	always_ff @(posedge clk_mist or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
			armed <= 1'b1;
		end else begin
			if (armed && coin_key) begin
				count <= CNT_W'(`COIN_PULSE_CYCLES);
				armed <= 1'b0; // one credit per press
			end else begin
				if (count != '0) begin
					count <= count - 1'b1;
				end
				if (!coin_key && count == '0) begin
					armed <= 1'b1; // released and pulse over
				end
			end
		end
	end

	assign coin_pulse = (count != '0);

	// the pulse must be gone exactly COIN_PULSE_CYCLES after it rose
	a_pulse_len: assert property (
		@(posedge clk_mist) disable iff (!arst_n)
		$rose(coin_pulse) |-> ##`COIN_PULSE_CYCLES !coin_pulse
	) else $error("coin_pulse held longer than %0d cycles", `COIN_PULSE_CYCLES);

	// no second pulse without a release in between
	a_rearm: assert property (
		@(posedge clk_mist) disable iff (!arst_n)
		$fell(coin_pulse) && coin_key |=> !coin_pulse
	) else $error("coin_pulse retriggered while key still held");

endmodule

/* design/control_mapper.sv */
`timescale 1ns/1ps

`include "invaders_macros.svh"

module control_mapper (
	input  logic                              clk_mist,
	input  logic                              arst_n,
	input  logic                              rotate,
	input  invaders_input_pkg::button_state_t buttons,
	input  logic                  [`JOY_W-1:0] joystick_0,
	input  logic                  [`JOY_W-1:0] joystick_1,
	input  logic                              coin_pulse,
	output invaders_input_pkg::ctrl_word_t    ctrl_word
);

	logic dir_right;
	logic dir_left;
	logic dir_down;
	logic dir_up;
	logic btn_fire;
	logic btn_bomb;

	invaders_input_pkg::ctrl_word_t word_next;

	// keys and both joysticks merged per direction
	assign dir_right = buttons.right | joystick_0[0] | joystick_1[0];
	assign dir_left  = buttons.left  | joystick_0[1] | joystick_1[1];
	assign dir_down  = buttons.down  | joystick_0[2] | joystick_1[2];
	assign dir_up    = buttons.up    | joystick_0[3] | joystick_1[3];
	assign btn_fire  = buttons.fire1 | joystick_0[4] | joystick_1[4];
	assign btn_bomb  = buttons.fire2 | joystick_0[5] | joystick_1[5];

	always_comb begin
		word_next.coin = coin_pulse;
		word_next.sel1 = buttons.one_player;
		word_next.sel2 = buttons.two_players;
		word_next.fire = btn_fire;
		word_next.bomb = btn_bomb;
		if (rotate) begin
			word_next.move_up    = dir_up;
			word_next.move_down  = dir_down;
			word_next.move_left  = dir_left;
			word_next.move_right = dir_right;
		end else begin
			// cabinet orientation, screen turned a quarter
			word_next.move_up    = dir_right;
			word_next.move_down  = dir_left;
			word_next.move_left  = dir_up;
			word_next.move_right = dir_down;
		end
	end

	always_ff @(posedge clk_mist or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_word <= '0;
		end else begin
			ctrl_word <= word_next;
		end
	end

endmodule

/* design/handshake_fsm.sv */
`timescale 1ns/1ps

module handshake_fsm (
	input  logic                           clk_mist,
	input  logic                           arst_n,
	input  invaders_input_pkg::ctrl_word_t ctrl_word,
	input  logic                           ctrl_ack,
	output logic                           ctrl_req,
	output invaders_input_pkg::ctrl_word_t ctrl_data
);

	invaders_input_pkg::hs_state_t state;

	// ctrl_data doubles as the last sent word
	always_ff @(posedge clk_mist or negedge arst_n) begin
		if (!arst_n) begin
			state     <= invaders_input_pkg::idle;
			ctrl_req  <= 1'b0;
			ctrl_data <= '0;
		end else begin
			case (state)
				invaders_input_pkg::idle: begin
					if (ctrl_word != ctrl_data) begin
						ctrl_data <= ctrl_word; // latched with req rise
						ctrl_req  <= 1'b1;
						state     <= invaders_input_pkg::req_high;
					end
				end
				invaders_input_pkg::req_high: begin
					if (ctrl_ack) begin
						ctrl_req <= 1'b0;
						state    <= invaders_input_pkg::wait_release;
					end
				end
				invaders_input_pkg::wait_release: begin
					if (!ctrl_ack) begin
						state <= invaders_input_pkg::idle; // core has let go
					end
				end
				default: begin
					ctrl_req <= 1'b0;
					state    <= invaders_input_pkg::idle;
				end
			endcase
		end
	end

	// req may only drop after the core acknowledged
	a_req_fall: assert property (
		@(posedge clk_mist) disable iff (!arst_n)
		$fell(ctrl_req) |-> $past(ctrl_ack)
	) else $error("ctrl_req fell without ctrl_ack");

	// payload frozen for the whole request phase
	a_data_stable: assert property (
		@(posedge clk_mist) disable iff (!arst_n)
		ctrl_req && $past(ctrl_req) |-> $stable(ctrl_data)
	) else $error("ctrl_data changed while ctrl_req high");

	// a new request never starts on a stale ack
	a_no_early_req: assert property (
		@(posedge clk_mist) disable iff (!arst_n)
		$rose(ctrl_req) |-> !$past(ctrl_ack)
	) else $error("ctrl_req rose while ctrl_ack still high");

endmodule

/* design/invaders_input_pkg.sv */
package invaders_input_pkg;

	// held state of every game key, 1 while the key is down
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic one_player;
		logic two_players;
		logic fire1;
		logic fire2;
		logic fire3;
	} button_state_t;

	// control word seen by the game core, all active high
	typedef struct packed {
		logic coin;
		logic sel1;
		logic sel2;
		logic fire;
		logic bomb;
		logic move_left;
		logic move_right;
		logic move_up;
		logic move_down;
	} ctrl_word_t;

	typedef enum logic [7:0] {
		sc_up     = 8'h75,
		sc_down   = 8'h72,
		sc_left   = 8'h6B,
		sc_right  = 8'h74,
		sc_esc    = 8'h76, // coin
		sc_f1     = 8'h05,
		sc_f2     = 8'h06,
		sc_space  = 8'h29,
		sc_alt    = 8'h11,
		sc_ctrl   = 8'h14
	} scan_code_t;

	typedef enum logic [1:0] {
		idle,
		req_high,
		wait_release
	} hs_state_t;

endpackage

/* design/invaders_input_top.sv */
`timescale 1ns/1ps

`include "invaders_macros.svh"

module invaders_input_top (
	input  logic               clk_mist,
	input  logic               arst_n,
	input  logic               key_strobe,
	input  logic               key_pressed,
	input  logic         [7:0] key_code,
	input  logic [`JOY_W-1:0]  joystick_0,
	input  logic [`JOY_W-1:0]  joystick_1,
	input  logic               rotate,
	input  logic               ctrl_ack,
	output logic               ctrl_req,
	output logic [`CTRL_W-1:0] ctrl_data
);

	invaders_input_pkg::button_state_t buttons;
	invaders_input_pkg::ctrl_word_t    ctrl_word;
	logic                              coin_pulse;

	key_decoder u_key_decoder (
		.clk_mist    (clk_mist),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.buttons     (buttons)
	);

	coin_pulse_timer u_coin_pulse_timer (
		.clk_mist   (clk_mist),
		.arst_n     (arst_n),
		.coin_key   (buttons.coin),
		.coin_pulse (coin_pulse)
	);

	control_mapper u_control_mapper (
		.clk_mist   (clk_mist),
		.arst_n     (arst_n),
		.rotate     (rotate),
		.buttons    (buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.coin_pulse (coin_pulse),
		.ctrl_word  (ctrl_word)
	);

	handshake_fsm u_handshake_fsm (
		.clk_mist  (clk_mist),
		.arst_n    (arst_n),
		.ctrl_word (ctrl_word),
		.ctrl_ack  (ctrl_ack),
		.ctrl_req  (ctrl_req),
		.ctrl_data (ctrl_data) // flat at the boundary
	);

endmodule

/* design/invaders_macros.svh */
`ifndef INVADERS_MACROS_SVH
`define INVADERS_MACROS_SVH

// cycles the coin line stays high per press
`define COIN_PULSE_CYCLES 16

// joystick port width
`define JOY_W 8

// control word width, matches ctrl_word_t
`define CTRL_W 9

`endif

/* design/key_decoder.sv */
`timescale 1ns/1ps

module key_decoder (
	input  logic                              clk_mist,
	input  logic                              arst_n,
	input  logic                              key_strobe,
	input  logic                              key_pressed,
	input  logic                        [7:0] key_code,
	output invaders_input_pkg::button_state_t buttons
);

	// each key keeps its state until the opposite event for that code
	always_ff @(posedge clk_mist or negedge arst_n) begin
		if (!arst_n) begin
			buttons <= '0;
		end else if (key_strobe) begin
			case (key_code)
				invaders_input_pkg::sc_up: begin
					buttons.up <= key_pressed;
				end
				invaders_input_pkg::sc_down: begin
					buttons.down <= key_pressed;
				end
				invaders_input_pkg::sc_left: begin
					buttons.left <= key_pressed;
				end
				invaders_input_pkg::sc_right: begin
					buttons.right <= key_pressed;
				end
				invaders_input_pkg::sc_esc: begin
					buttons.coin <= key_pressed;
				end
				invaders_input_pkg::sc_f1: begin
					buttons.one_player <= key_pressed;
				end
				invaders_input_pkg::sc_f2: begin
					buttons.two_players <= key_pressed;
				end
				invaders_input_pkg::sc_space: begin
					buttons.fire1 <= key_pressed;
				end
				invaders_input_pkg::sc_alt: begin
					buttons.fire2 <= key_pressed;
				end
				invaders_input_pkg::sc_ctrl: begin
					buttons.fire3 <= key_pressed;
				end
				default: ; // unknown code, no change
			endcase
		end
	end

endmodule

/* invaders_input.f */
+incdir+design
design/invaders_input_pkg.sv
design/key_decoder.sv
design/coin_pulse_timer.sv
design/control_mapper.sv
design/handshake_fsm.sv
design/invaders_input_top.sv
bench/invaders_checker.sv
bench/tb_invaders_input.sv
